// ==== design/uart_bridge_pkg.sv ====
package uart_bridge_pkg;

  // Command and byte sizes.
  localparam int CMD_WIDTH  = 16;
  localparam int BYTE_WIDTH = CMD_WIDTH / 2;

  // Start, eight data bits, odd parity, stop.
  localparam int FRAME_BITS = 11;

  // 50 MHz clock at 115200 baud.
  localparam int BAUD_DIV = 434;

  // High byte goes out first.
  typedef struct packed {
    logic [BYTE_WIDTH-1:0] hi_byte;
    logic [BYTE_WIDTH-1:0] lo_byte;
  } cmd_word_t;

  // One received frame with its error flags.
  typedef struct packed {
    logic [BYTE_WIDTH-1:0] data;
    logic                  parity_err;
    logic                  frame_err;
  } rx_word_t;

endpackage

// ==== design/cmd_serializer.sv ====
`timescale 1ns/1ps

module cmd_serializer (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  uart_bridge_pkg::cmd_word_t             cmd_in,
  input  logic                                   cmd_vld,
  output logic                                   cmd_rdy,
  input  logic                                   byte_done,
  output logic                                   byte_start,
  output logic [uart_bridge_pkg::BYTE_WIDTH-1:0] tx_byte
);

  import uart_bridge_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_HI,
    S_WAIT_HI,
    S_SEND_LO,
    S_WAIT_LO
  } state_t;

  state_t    state;
  state_t    state_nxt;
  cmd_word_t cmd_reg;

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (cmd_vld) begin
          state_nxt = S_SEND_HI;
        end
      end
      S_SEND_HI: state_nxt = S_WAIT_HI;
      S_WAIT_HI: begin
        if (byte_done) begin
          state_nxt = S_SEND_LO;
        end
      end
      S_SEND_LO: state_nxt = S_WAIT_LO;
      S_WAIT_LO: begin
        if (byte_done) begin
          state_nxt = S_IDLE;
        end
      end
      default: state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Command is captured only on the accepting edge.
  always_ff @(posedge clk) begin
    if (cmd_vld && cmd_rdy) begin
      cmd_reg <= cmd_in;
    end
  end

  assign cmd_rdy    = (state == S_IDLE);
  assign byte_start = (state == S_SEND_HI) || (state == S_SEND_LO);

  // Held stable while the transmitter works on the frame.
  assign tx_byte = (state == S_SEND_HI || state == S_WAIT_HI) ? cmd_reg.hi_byte
                                                              : cmd_reg.lo_byte;

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   byte_start,
  input  logic [uart_bridge_pkg::BYTE_WIDTH-1:0] tx_byte,
  output logic                                   byte_done,
  output logic                                   tx
);

  import uart_bridge_pkg::*;

  logic                          busy;
  logic [FRAME_BITS-1:0]         shreg;
  logic [$clog2(BAUD_DIV)-1:0]   baud_cnt;
  logic [$clog2(FRAME_BITS)-1:0] bit_cnt;
  logic                          bit_end;
  logic                          frame_end;

  assign bit_end   = (baud_cnt == $clog2(BAUD_DIV)'(BAUD_DIV - 1));
  assign frame_end = bit_end && (bit_cnt == $clog2(FRAME_BITS)'(FRAME_BITS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (!busy && byte_start) begin
      busy <= 1'b1;
    end else if (frame_end) begin
      busy <= 1'b0;
    end
  end

  // Baud and bit counters run only during a frame.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (!busy) begin
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (bit_end) begin
      baud_cnt <= '0;
      bit_cnt  <= bit_cnt + 1'b1;
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Frame is stop, parity, data MSB..LSB, start; bit 0 leaves first.
  always_ff @(posedge clk) begin
    if (!busy && byte_start) begin
      shreg <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
    end else if (busy && bit_end) begin
      shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
    end
  end

  // Line is registered, so it trails the shift register by one cycle.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx <= 1'b1;
    end else begin
      tx <= busy ? shreg[0] : 1'b1;
    end
  end

  // Lands in the last cycle of the stop bit on the line.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_done <= 1'b0;
    end else begin
      byte_done <= busy && frame_end;
    end
  end

endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      rx,
  output logic                      read_rdy,
  output uart_bridge_pkg::rx_word_t read_data
);

  import uart_bridge_pkg::*;

  typedef enum logic [1:0] {
    R_IDLE,
    R_START,
    R_BITS,
    R_WAIT_HIGH
  } rx_state_t;

  rx_state_t                     state;
  logic                          rx_meta;
  logic                          rx_sync;
  logic [$clog2(BAUD_DIV)-1:0]   baud_cnt;
  logic [$clog2(FRAME_BITS)-1:0] bit_idx;
  logic [BYTE_WIDTH:0]           rx_shift;
  logic                          half_bit;
  logic                          full_bit;
  logic                          stop_bit;

  // Two-stage synchronizer, idle high.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  assign half_bit = (baud_cnt == $clog2(BAUD_DIV)'(BAUD_DIV / 2 - 1));
  assign full_bit = (baud_cnt == $clog2(BAUD_DIV)'(BAUD_DIV - 1));

  // Data and parity come first, the stop bit is the last sample.
  assign stop_bit = (bit_idx == $clog2(FRAME_BITS)'(FRAME_BITS - 2));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= R_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else begin
      case (state)
        R_IDLE: begin
          baud_cnt <= '0;
          bit_idx  <= '0;
          if (!rx_sync) begin
            state <= R_START;
          end
        end
        R_START: begin
          if (half_bit) begin
            baud_cnt <= '0;
            // A short glitch is dropped here.
            state <= rx_sync ? R_IDLE : R_BITS;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        R_BITS: begin
          if (full_bit) begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            if (stop_bit) begin
              state <= rx_sync ? R_IDLE : R_WAIT_HIGH;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        R_WAIT_HIGH: begin
          if (rx_sync) begin
            state <= R_IDLE;
          end
        end
        default: state <= R_IDLE;
      endcase
    end
  end

  // LSB arrives first and ends up in bit 0, parity on top.
  always_ff @(posedge clk) begin
    if (state == R_BITS && full_bit && !stop_bit) begin
      rx_shift <= {rx_sync, rx_shift[BYTE_WIDTH:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_rdy  <= 1'b0;
      read_data <= '0;
    end else begin
      read_rdy <= 1'b0;
      if (state == R_BITS && full_bit && stop_bit) begin
        read_rdy             <= 1'b1;
        read_data.data       <= rx_shift[BYTE_WIDTH-1:0];
        // Odd parity: an even ones count is an error.
        read_data.parity_err <= ~^rx_shift;
        read_data.frame_err  <= ~rx_sync;
      end
    end
  end

endmodule

// ==== design/uart_bridge.sv ====
`timescale 1ns/1ps

module uart_bridge (
  input  logic                       clk,
  input  logic                       rst_n,
  input  uart_bridge_pkg::cmd_word_t cmd_in,
  input  logic                       cmd_vld,
  output logic                       cmd_rdy,
  input  logic                       rx,
  output logic                       tx,
  output logic                       read_rdy,
  output uart_bridge_pkg::rx_word_t  read_data
);

  import uart_bridge_pkg::*;

  logic                  byte_start;
  logic                  byte_done;
  logic [BYTE_WIDTH-1:0] tx_byte;

  // Splits each command into two bytes, high first.
  cmd_serializer u_cmd_serializer (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .byte_done  (byte_done),
    .byte_start (byte_start),
    .tx_byte    (tx_byte)
  );

  uart_tx u_uart_tx (
    .clk        (clk),
    .rst_n      (rst_n),
    .byte_start (byte_start),
    .tx_byte    (tx_byte),
    .byte_done  (byte_done),
    .tx         (tx)
  );

  uart_rx u_uart_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 4 ns period.
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset spans two rising edges and lets go just after the second.
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

// ==== tb/uart_bridge_assert.sv ====
`timescale 1ns/1ps

module uart_bridge_assert (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic read_rdy
);

  // An accepted command makes the serializer busy on the next cycle.
  property p_accept_busy;
    @(posedge clk) disable iff (!rst_n) (cmd_vld && cmd_rdy) |=> !cmd_rdy;
  endproperty

  property p_read_pulse;
    @(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy;
  endproperty

  // Nothing is on the line while the bridge is idle.
  property p_idle_line;
    @(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx;
  endproperty

  a_accept_busy: assert property (p_accept_busy)
    else $error("cmd_rdy stayed high after an accepted command");
  a_read_pulse: assert property (p_read_pulse)
    else $error("read_rdy was high for two cycles in a row");
  a_idle_line: assert property (p_idle_line)
    else $error("tx was low while cmd_rdy was high");

endmodule

bind uart_bridge uart_bridge_assert u_bridge_assert (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy)
);

// ==== tb/tb_uart_bridge.sv ====
`timescale 1ns/1ps

module tb_uart_bridge;

  import uart_bridge_pkg::*;

  logic        clk;
  logic        rst_n;
  cmd_word_t   cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        rx;
  logic        tx;
  logic        read_rdy;
  rx_word_t    read_data;
  logic        use_inj;
  logic        inj_line;

  rx_word_t    exp_q[$];
  int          rd_idx = 0;
  int          mon_err = 0;
  int          chk_err;
  int          tests_pass;
  int          tests_fail;
  int          strays;
  logic [31:0] rng_state;
  logic        timed_out;

  // Receiver sees either its own transmitter or the frame injector.
  assign rx = use_inj ? inj_line : tx;

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_bridge dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  function automatic logic [31:0] next_rand();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  // Each read word is matched against the next expected entry.
  always @(negedge clk) begin
    if (rst_n && read_rdy) begin
      if (rd_idx >= exp_q.size()) begin
        $display("** Error [%0t] unexpected read word, data %02h", $time, read_data.data);
        mon_err++;
      end else begin
        if (read_data !== exp_q[rd_idx]) begin
          $display("** Error [%0t] read word %0d: got %02h pe %0b fe %0b, exp %02h pe %0b fe %0b",
                   $time, rd_idx, read_data.data, read_data.parity_err, read_data.frame_err,
                   exp_q[rd_idx].data, exp_q[rd_idx].parity_err, exp_q[rd_idx].frame_err);
          mon_err++;
        end
        rd_idx++;
      end
    end
  end

  // Stray strobes are only fired while cmd_rdy is low.
  task automatic wait_cmd_rdy(input logic with_strays);
    int          n;
    logic [31:0] r;
    n = 0;
    @(posedge clk);
    #1;
    while (!cmd_rdy && n < 30 * BAUD_DIV) begin
      cmd_vld = 1'b0;
      if (with_strays && next_rand() % 300 == 0) begin
        r       = next_rand();
        cmd_in  = r[CMD_WIDTH-1:0];
        cmd_vld = 1'b1;
        strays++;
      end
      @(posedge clk);
      #1;
      n++;
    end
    cmd_vld = 1'b0;
    if (!cmd_rdy) begin
      $display("timeout: cmd_rdy did not return high");
      timed_out = 1'b1;
    end
  endtask

  task automatic issue_cmd(input logic with_strays, input int gap);
    logic [31:0] r;
    cmd_word_t   c;
    rx_word_t    w;
    wait_cmd_rdy(with_strays);
    if (!timed_out) begin
      // Idle gap with the bridge ready.
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      r       = next_rand();
      c       = r[CMD_WIDTH-1:0];
      cmd_in  = c;
      cmd_vld = 1'b1;
      @(posedge clk);
      #1;
      cmd_vld = 1'b0;
      if (cmd_rdy !== 1'b0) begin
        $display("** Error [%0t] cmd_rdy still high after command %04h", $time, c);
        chk_err++;
      end
      // High byte first, clean line so no flags.
      w.data       = c.hi_byte;
      w.parity_err = 1'b0;
      w.frame_err  = 1'b0;
      exp_q.push_back(w);
      w.data = c.lo_byte;
      exp_q.push_back(w);
    end
  endtask

  task automatic drain(input string what);
    int n;
    n = 0;
    while (rd_idx < exp_q.size() && n < 30 * BAUD_DIV) begin
      @(posedge clk);
      n++;
    end
    if (rd_idx < exp_q.size()) begin
      $display("timeout: %s still waits for %0d read words", what, exp_q.size() - rd_idx);
      timed_out = 1'b1;
    end
  endtask

  // Start, data LSB first, parity, stop; the line is left high afterwards.
  task automatic send_frame(input logic [BYTE_WIDTH-1:0] data, input logic flip_par,
                            input logic low_stop);
    logic [FRAME_BITS-1:0] bits;
    rx_word_t              w;
    bits   = {~low_stop, (~^data) ^ flip_par, data, 1'b0};
    w.data = data;
    // Ones over data and parity must be odd.
    w.parity_err = ($countones(bits[FRAME_BITS-2:1]) % 2) == 0;
    w.frame_err  = ~bits[FRAME_BITS-1];
    exp_q.push_back(w);
    @(posedge clk);
    #1;
    for (int i = 0; i < FRAME_BITS; i++) begin
      inj_line = bits[i];
      repeat (BAUD_DIV) @(posedge clk);
      #1;
    end
    inj_line = 1'b1;
  endtask

  task automatic report_test(input string name, input int base);
    if (chk_err + mon_err == base && !timed_out) begin
      $display("test %s: ok", name);
      tests_pass++;
    end else begin
      $display("test %s: failed", name);
      tests_fail++;
    end
  endtask

  initial begin
    int          base;
    int          n;
    logic [31:0] r;
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    use_inj    = 1'b0;
    inj_line   = 1'b1;
    rng_state  = 32'h68f1;
    timed_out  = 1'b0;
    chk_err    = 0;
    tests_pass = 0;
    tests_fail = 0;
    strays     = 0;

    n = 0;
    while (!rst_n && n < 20) begin
      @(posedge clk);
      n++;
    end
    #1;
    if (!rst_n) begin
      $display("timeout: reset was never released");
      timed_out = 1'b1;
    end

    if (!timed_out) begin
      base = chk_err + mon_err;
      if (tx !== 1'b1) begin
        $display("** Error [%0t] tx is not idle high after reset", $time);
        chk_err++;
      end
      if (cmd_rdy !== 1'b1) begin
        $display("** Error [%0t] cmd_rdy is not high after reset", $time);
        chk_err++;
      end
      if (read_rdy !== 1'b0) begin
        $display("** Error [%0t] read_rdy is not low after reset", $time);
        chk_err++;
      end
      if (read_data !== '0) begin
        $display("** Error [%0t] read_data is not zero after reset", $time);
        chk_err++;
      end
      report_test("reset values", base);
    end

    if (!timed_out) begin
      base = chk_err + mon_err;
      for (int i = 0; i < 40 && !timed_out; i++) begin
        r = next_rand();
        issue_cmd(1'b0, int'(r % 40));
      end
      drain("loopback");
      report_test("loopback of 40 commands", base);
    end

    if (!timed_out) begin
      base = chk_err + mon_err;
      for (int i = 0; i < 15 && !timed_out; i++) begin
        r = next_rand();
        issue_cmd(1'b1, int'(r % 40));
      end
      wait_cmd_rdy(1'b0);
      drain("busy rejection");
      // Room for any word that should not exist.
      repeat (2 * FRAME_BITS * BAUD_DIV) @(posedge clk);
      report_test($sformatf("busy rejection with %0d strays", strays), base);
    end

    if (!timed_out) begin
      base = chk_err + mon_err;
      @(posedge clk);
      #1;
      use_inj = 1'b1;
      r = next_rand();
      send_frame(r[BYTE_WIDTH-1:0], 1'b1, 1'b0);
      drain("parity error frame");
      report_test("parity error", base);
    end

    if (!timed_out) begin
      base = chk_err + mon_err;
      r = next_rand();
      send_frame(r[BYTE_WIDTH-1:0], 1'b0, 1'b1);
      repeat (2 * BAUD_DIV) @(posedge clk);
      r = next_rand();
      send_frame(r[BYTE_WIDTH-1:0], 1'b0, 1'b0);
      drain("framing error frames");
      @(posedge clk);
      #1;
      use_inj = 1'b0;
      report_test("framing error and recovery", base);
    end

    if (!timed_out) begin
      base = chk_err + mon_err;
      for (int i = 0; i < 10 && !timed_out; i++) begin
        issue_cmd(1'b0, 0);
      end
      drain("back-to-back");
      report_test("back-to-back commands", base);
    end

    $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
    if (tests_fail == 0 && chk_err + mon_err == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
design/uart_bridge_pkg.sv
design/cmd_serializer.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_bridge.sv
tb/tb_clk_gen.sv
tb/uart_bridge_assert.sv
tb/tb_uart_bridge.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_uart_bridge
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
